// File: la_top.f
la_pkg.sv
la_sampler.sv
la_sample_ram.sv
la_cmd_decoder.sv
la_ctrl.sv
la_tx.sv
la_top.sv
tb_clk_gen.sv
tb_la_top.sv

// File: tb_la_top.sv
// logic analyzer testbench, random probe data and commands checked against a ring model
module tb_la_top import la_pkg::*; ();

  localparam logic [31:0] SEED = 32'h90c2e818;

  typedef enum logic [1:0] {M_IDLE, M_TRIG, M_FROZEN} phase_t;

  logic            clk_i;
  logic            rst_in;
  logic [OP_W-1:0] op_i;
  sample_t         cmd_i;
  logic            cmd_stb_i;
  sample_t         probe_i;
  logic [7:0]      tx_byte_o;
  logic            tx_stb_o;
  logic            busy_o;

  logic [31:0]       lfsr = SEED;
  phase_t            m_phase;
  logic [DIV_W-1:0]  m_tick, m_divq, m_div;   // sampler and divider mirror
  logic              m_stb;
  sample_t           m_smpl;
  logic [CNT_W-1:0]  m_dly, m_rd, m_cnt;
  logic              m_run;
  logic [ADDR_W-1:0] m_ptr;
  sample_t           m_ring [RAM_DEPTH];      // shadow of the sample memory
  sample_t           exp_q [$];               // words expected from one readback
  logic [7:0]        rx_q [$];                // bytes seen on the output

  tb_clk_gen u_clk (
    .clk_o  (clk_i),
    .rst_no (rst_in)
  );

  la_top u_dut (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .op_i      (op_i),
    .cmd_i     (cmd_i),
    .cmd_stb_i (cmd_stb_i),
    .probe_i   (probe_i),
    .tx_byte_o (tx_byte_o),
    .tx_stb_o  (tx_stb_o),
    .busy_o    (busy_o)
  );

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};           // one step per bit
      lfsr = galois_step(lfsr);
    end
    return v;
  endfunction

  function automatic sample_t cnt_cmd(input logic [CNT_W-1:0] dly, input logic [CNT_W-1:0] rd);
    return {rd[7:0], rd[15:8], dly[7:0], dly[15:8]};  // low byte above high byte
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input sample_t got, input sample_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail at time %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail at time %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    probe_i   <= take_bits(32);          // fresh probe value every cycle
    cmd_stb_i <= 1'b0;
  endtask

  task automatic send_cmd(input logic [OP_W-1:0] op, input sample_t cmd);
    next_cycle();
    op_i      <= op;
    cmd_i     <= cmd;
    cmd_stb_i <= 1'b1;
  endtask

  task automatic wait_busy(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (busy_o !== level) begin
      if (cycles >= limit) begin
        abort_run($sformatf("timeout after %0d cycles waiting for %s", limit, what));
      end
      next_cycle();
      cycles++;
    end
  endtask

  // one run, then every read back word against the model
  task automatic run_capture(input int rd_words, input bit extra_run, input string what);
    sample_t got;
    rx_q.delete();
    exp_q.delete();
    send_cmd(OP_RUN, take_bits(32));
    wait_busy(1'b1, 8, "busy_o to rise after a run");
    if (extra_run) begin
      send_cmd(OP_RUN, take_bits(32));   // must be ignored
    end
    wait_busy(1'b0, 2000, "busy_o to fall after readback");
    repeat (2) next_cycle();
    check_count(exp_q.size(), rd_words, {what, " model words"});
    check_count(rx_q.size(), 4 * rd_words, {what, " byte count"});
    for (int i = 0; i < rd_words; i++) begin
      got = {rx_q[4*i+3], rx_q[4*i+2], rx_q[4*i+1], rx_q[4*i]};
      check_word(got, exp_q[i], $sformatf("%s word %0d", what, i));
    end
  endtask

  task automatic store_sample();
    m_ring[m_ptr] = m_smpl;
    m_ptr         = m_ptr + 1'b1;
  endtask

  // reference model, every value read here is the one before the edge
  always @(posedge clk_i) begin : model_step
    logic [ADDR_W-1:0] ra;
    if (!rst_in) begin
      m_phase = M_IDLE;
      m_tick  = '0;
      m_divq  = RST_DIV;
      m_div   = RST_DIV;
      m_stb   = 1'b0;
      m_dly   = RST_DLY;
      m_rd    = RST_RD;
      m_cnt   = '0;
      m_run   = 1'b0;
      m_ptr   = '0;
    end else begin
      case (m_phase)
        M_IDLE: begin
          if (m_stb) store_sample();
          if (m_run) begin
            m_phase = M_TRIG;
            m_cnt   = '0;
          end
        end
        M_TRIG: begin
          if (m_cnt == m_dly) begin
            m_phase = M_FROZEN;          // ring is fixed from here on
            ra      = m_ptr;
            for (int i = 0; i < m_rd; i++) begin
              ra = ra - 1'b1;            // newest first
              exp_q.push_back(m_ring[ra]);
            end
            m_ptr = ra;                  // readback walks the pointer back
          end else if (m_stb) begin
            store_sample();
            m_cnt = m_cnt + 1'b1;
          end
        end
        default: begin
          if (!busy_o) begin
            m_phase = M_IDLE;
            if (m_stb) store_sample();
          end
        end
      endcase
      if (m_tick == m_divq) begin        // capture every div+1 cycles
        m_smpl = probe_i;
        m_tick = '0;
        m_divq = m_div;
        m_stb  = 1'b1;
      end else begin
        m_tick = m_tick + 1'b1;
        m_stb  = 1'b0;
      end
      m_run = cmd_stb_i && (op_i == OP_RUN);
      if (cmd_stb_i && (op_i == OP_SET_CNT)) begin
        m_dly = {cmd_i[7:0], cmd_i[15:8]};
        m_rd  = {cmd_i[23:16], cmd_i[31:24]};
      end
      if (cmd_stb_i && (op_i == OP_SET_DIV)) m_div = cmd_i[7:0];
    end
  end

  always @(posedge clk_i) begin
    if (rst_in && tx_stb_o) rx_q.push_back(tx_byte_o);
  end

  initial begin : stimulus
    int cycles;
    int busy_cycles;
    int rd;
    int dly;
    op_i      = '0;
    cmd_i     = '0;
    cmd_stb_i = 1'b0;
    probe_i   = '0;
    cycles    = 0;
    while (!rst_in) begin
      if (cycles >= 40) abort_run("timeout waiting for reset to be released");
      next_cycle();
      cycles++;
    end

    // quiet outputs without a run
    busy_cycles = 0;
    rx_q.delete();
    repeat (200) begin
      next_cycle();
      if (busy_o !== 1'b0) busy_cycles++;
    end
    check_count(busy_cycles, 0, "busy cycles without a run");
    check_count(rx_q.size(), 0, "bytes without a run");

    run_capture(1, 1'b0, "reset counts");

    repeat (6) begin                     // random counts at the reset divider
      rd  = 1 + take_bits(5);
      dly = take_bits(5) % 21;
      send_cmd(OP_SET_CNT, cnt_cmd(dly, rd));
      repeat (take_bits(3)) next_cycle();
      run_capture(rd, 1'b0, $sformatf("counts dly %0d rd %0d", dly, rd));
    end

    repeat (5) begin                     // random divider and counts
      send_cmd(OP_SET_DIV, take_bits(32) & 32'hffff_ff07);
      rd  = 1 + take_bits(5);
      dly = take_bits(5) % 21;
      send_cmd(OP_SET_CNT, cnt_cmd(dly, rd));
      repeat (take_bits(4) + 8) next_cycle();
      run_capture(rd, 1'b0, $sformatf("divider run dly %0d rd %0d", dly, rd));
    end

    send_cmd(8'h7f, take_bits(32));      // unknown opcode
    send_cmd(OP_SET_CNT, cnt_cmd(0, 3));
    repeat (4) next_cycle();
    run_capture(3, 1'b1, "run while busy");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
// testbench clock and reset source, 40 unit period and a 16 cycle active low reset
module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;                      // released on a rising edge
  end

endmodule

// File: la_top.sv
// logic analyzer top level, wires decoder, sampler, sample ring, controller and transmitter
module la_top import la_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_in,
  input  logic [OP_W-1:0] op_i,          // command opcode
  input  sample_t         cmd_i,         // command word
  input  logic            cmd_stb_i,
  input  sample_t         probe_i,       // probe bus under observation
  output logic [7:0]      tx_byte_o,
  output logic            tx_stb_o,
  output logic            busy_o
);

  logic              run;
  logic [CNT_W-1:0]  dly_cnt;
  logic [CNT_W-1:0]  rd_cnt;
  logic [DIV_W-1:0]  div;
  sample_t           smpl;
  logic              smpl_stb;
  logic              we;
  logic [ADDR_W-1:0] addr;
  sample_t           rdata;
  sample_t           word;
  logic              word_stb;
  logic              tx_rdy;

  la_cmd_decoder u_dec (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .op_i      (op_i),
    .cmd_i     (cmd_i),
    .cmd_stb_i (cmd_stb_i),
    .run_o     (run),
    .dly_cnt_o (dly_cnt),
    .rd_cnt_o  (rd_cnt),
    .div_o     (div)
  );

  la_sampler u_smp (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .probe_i    (probe_i),
    .div_i      (div),
    .smpl_o     (smpl),
    .smpl_stb_o (smpl_stb)
  );

  la_sample_ram u_ram (
    .clk_i   (clk_i),
    .we_i    (we),
    .waddr_i (addr),                     // one pointer serves write and read
    .raddr_i (addr),
    .wdata_i (smpl),
    .rdata_o (rdata)
  );

  la_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .run_i      (run),
    .dly_cnt_i  (dly_cnt),
    .rd_cnt_i   (rd_cnt),
    .smpl_stb_i (smpl_stb),
    .rdata_i    (rdata),
    .tx_rdy_i   (tx_rdy),
    .we_o       (we),
    .addr_o     (addr),
    .word_o     (word),
    .word_stb_o (word_stb),
    .busy_o     (busy_o)
  );

  la_tx u_tx (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .word_i     (word),
    .word_stb_i (word_stb),
    .rdy_o      (tx_rdy),
    .byte_o     (tx_byte_o),
    .byte_stb_o (tx_stb_o)
  );

endmodule

// File: la_tx.sv
// byte transmitter, sends each 32-bit word as four paced bytes, least significant first
module la_tx import la_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_in,
  input  sample_t    word_i,
  input  logic       word_stb_i,
  output logic       rdy_o,              // high when a new word is accepted
  output logic [7:0] byte_o,
  output logic       byte_stb_o
);

  logic              busy;
  logic [1:0]        idx;                // byte on the output
  logic [GAP_W-1:0]  gap;                // cycles since the last byte
  sample_t           shreg;              // bytes still to send

  assign rdy_o = !busy;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      busy       <= 1'b0;
      idx        <= '0;
      gap        <= '0;
      byte_stb_o <= 1'b0;
    end else begin
      byte_stb_o <= 1'b0;
      if (word_stb_i) begin
        busy       <= 1'b1;
        idx        <= '0;
        gap        <= '0;
        byte_stb_o <= 1'b1;              // byte 0 goes out right away
      end else if (busy) begin
        if (idx == 2'd3) begin
          busy <= 1'b0;                  // ready one cycle after the last byte
        end else if (gap == GAP_W'(BYTE_GAP - 1)) begin
          gap        <= '0;
          idx        <= idx + 1'b1;
          byte_stb_o <= 1'b1;
        end else begin
          gap <= gap + 1'b1;
        end
      end
    end
  end

  // payload path follows the strobes above
  always_ff @(posedge clk_i) begin
    if (word_stb_i) begin
      byte_o <= word_i[7:0];
      shreg  <= {8'h00, word_i[SMPL_W-1:8]};
    end else if (busy && idx != 2'd3 && gap == GAP_W'(BYTE_GAP - 1)) begin
      byte_o <= shreg[7:0];
      shreg  <= {8'h00, shreg[SMPL_W-1:8]};
    end
  end

  a_no_stb_busy: assert property (
    @(posedge clk_i) disable iff (!rst_in) word_stb_i |-> rdy_o
  ) else $error("word accepted while transmitter busy");

endmodule

// File: la_ctrl.sv
// logic analyzer controller FSM for ring capture, trigger delay and newest-first readback
module la_ctrl import la_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_in,
  input  logic              run_i,       // arm pulse
  input  logic [CNT_W-1:0]  dly_cnt_i,   // post-trigger samples
  input  logic [CNT_W-1:0]  rd_cnt_i,    // words to read back
  input  logic              smpl_stb_i,  // new sample present
  input  sample_t           rdata_i,     // ram read data
  input  logic              tx_rdy_i,    // transmitter idle
  output logic              we_o,
  output logic [ADDR_W-1:0] addr_o,
  output sample_t           word_o,      // word for the transmitter
  output logic              word_stb_o,
  output logic              busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_TRIG,
    ST_TX,
    ST_WAIT
  } state_t;

  state_t             state;
  state_t             state_next;
  logic [CNT_W-1:0]   cnt;               // post-trigger writes, then words sent
  logic [CNT_W-1:0]   cnt_next;
  logic [ADDR_W-1:0]  ptr;               // next ring slot to write
  logic [ADDR_W-1:0]  ptr_next;

  assign word_o = rdata_i;               // async ram, valid with word_stb_o
  assign busy_o = (state != ST_IDLE);

  always_comb begin
    state_next = state;
    cnt_next   = cnt;
    ptr_next   = ptr;
    we_o       = 1'b0;
    word_stb_o = 1'b0;
    addr_o     = ptr;

    case (state)
      ST_IDLE: begin
        if (run_i) begin
          state_next = ST_TRIG;
          cnt_next   = '0;
        end
        if (smpl_stb_i) begin            // keep filling the ring while idle
          we_o     = 1'b1;
          ptr_next = ptr + 1'b1;
        end
      end

      ST_TRIG: begin
        // leaving trigger wins over a sample in the same cycle
        if (cnt == dly_cnt_i) begin
          state_next = ST_TX;
          cnt_next   = '0;
        end else if (smpl_stb_i) begin
          we_o     = 1'b1;
          ptr_next = ptr + 1'b1;
          cnt_next = cnt + 1'b1;
        end
      end

      ST_TX: begin
        if (cnt == rd_cnt_i) begin
          state_next = ST_IDLE;
        end else begin
          addr_o     = ptr - 1'b1;       // newest sample first
          ptr_next   = ptr - 1'b1;
          word_stb_o = 1'b1;
          cnt_next   = cnt + 1'b1;
          state_next = ST_WAIT;
        end
      end

      ST_WAIT: begin
        if (tx_rdy_i) begin
          state_next = ST_TX;
        end
      end

      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state <= ST_IDLE;
      cnt   <= '0;
      ptr   <= '0;
    end else begin
      state <= state_next;
      cnt   <= cnt_next;
      ptr   <= ptr_next;
    end
  end

  // the ring must stay frozen while it is being read back
  a_no_we_readback: assert property (
    @(posedge clk_i) disable iff (!rst_in)
      (state inside {ST_TX, ST_WAIT}) |-> !we_o
  ) else $error("sample written during readback");

  a_stb_when_ready: assert property (
    @(posedge clk_i) disable iff (!rst_in) word_stb_o |-> tx_rdy_i
  ) else $error("word strobe while transmitter busy");

endmodule

// File: la_cmd_decoder.sv
// command decoder, turns strobed opcode and command word pairs into run pulses and settings
module la_cmd_decoder import la_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_in,
  input  logic [OP_W-1:0]  op_i,
  input  sample_t          cmd_i,
  input  logic             cmd_stb_i,
  output logic             run_o,        // arm pulse to the controller
  output logic [CNT_W-1:0] dly_cnt_o,    // post-trigger sample count
  output logic [CNT_W-1:0] rd_cnt_o,     // readback word count
  output logic [DIV_W-1:0] div_o         // sample rate divider
);

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      run_o     <= 1'b0;
      dly_cnt_o <= RST_DLY;
      rd_cnt_o  <= RST_RD;
      div_o     <= RST_DIV;
    end else begin
      run_o <= 1'b0;
      if (cmd_stb_i) begin
        case (op_i)
          OP_SET_CNT: begin
            dly_cnt_o <= {cmd_i[7:0], cmd_i[15:8]};     // byte swapped fields
            rd_cnt_o  <= {cmd_i[23:16], cmd_i[31:24]};
          end
          OP_SET_DIV: begin
            div_o <= cmd_i[7:0];
          end
          OP_RUN: begin
            run_o <= 1'b1;                              // controller ignores it outside idle
          end
          default: begin
          end                                           // unknown opcode
        endcase
      end
    end
  end

  a_run_single: assert property (
    @(posedge clk_i) disable iff (!rst_in) run_o |=> !run_o
  ) else $error("run pulse longer than one cycle");

endmodule

// File: la_sample_ram.sv
// circular sample memory with registered write and combinational read
module la_sample_ram import la_pkg::*; (
  input  logic              clk_i,
  input  logic              we_i,        // write strobe from the controller
  input  logic [ADDR_W-1:0] waddr_i,     // ring write pointer
  input  logic [ADDR_W-1:0] raddr_i,     // readback address
  input  sample_t           wdata_i,     // sample from the sampler
  output sample_t           rdata_o
);

  sample_t mem [RAM_DEPTH];              // oldest entry is overwritten as the ring wraps

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = mem[raddr_i];         // same-cycle read for the controller

  // an unknown write address would corrupt an arbitrary ring slot
  a_waddr_known: assert property (
    @(posedge clk_i) we_i |-> !$isunknown(waddr_i)
  ) else $error("sample ram written with unknown address");

endmodule

// File: la_sampler.sv
// probe sampler, divides the clock by div+1 and captures the probe bus on each wrap
module la_sampler import la_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_in,
  input  sample_t          probe_i,      // probe bus
  input  logic [DIV_W-1:0] div_i,        // rate divider from the decoder
  output sample_t          smpl_o,       // last captured sample
  output logic             smpl_stb_o    // one cycle per capture
);

  logic [DIV_W-1:0] tick;                // runs 0 .. div_q
  logic [DIV_W-1:0] div_q;               // divider in use for this period
  logic             wrap;

  assign wrap = (tick == div_q);

  // a new divider is picked up only on a wrap, so the running period finishes
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      tick  <= '0;
      div_q <= RST_DIV;
    end else if (wrap) begin
      tick  <= '0;
      div_q <= div_i;
    end else begin
      tick  <= tick + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      smpl_stb_o <= 1'b0;
    end else begin
      smpl_stb_o <= wrap;                // high the cycle after the wrap
    end
  end

  // payload register, only valid with the strobe
  always_ff @(posedge clk_i) begin
    if (wrap) begin
      smpl_o <= probe_i;
    end
  end

endmodule

// File: la_pkg.sv
// logic analyzer shared widths, opcodes, reset values and the sample type
package la_pkg;

  // data path
  localparam int SMPL_W = 32;                 // sample and command word width
  localparam int ADDR_W = 5;                  // sample memory address width
  localparam int RAM_DEPTH = 1 << ADDR_W;     // 32 samples in the ring

  // counters
  localparam int CNT_W = 16;                  // delay and readback counts
  localparam int DIV_W = 8;                   // sample rate divider

  // command opcodes
  localparam int OP_W = 8;
  localparam logic [OP_W-1:0] OP_SET_CNT = 8'h01;  // load delay and readback counts
  localparam logic [OP_W-1:0] OP_SET_DIV = 8'h02;  // load divider
  localparam logic [OP_W-1:0] OP_RUN     = 8'h03;  // arm the trigger

  // byte transmitter pacing
  localparam int BYTE_GAP = 4;                // cycles between bytes
  localparam int GAP_W = $clog2(BYTE_GAP);    // gap counter width

  // register values after reset
  localparam logic [DIV_W-1:0] RST_DIV = 1;
  localparam logic [CNT_W-1:0] RST_DLY = 1;
  localparam logic [CNT_W-1:0] RST_RD  = 1;

  typedef logic [SMPL_W-1:0] sample_t;

endpackage
